// File: hw/core_pkg.sv
`default_nettype none

package core_pkg;

    // Datapath widths
    localparam int WORD_W    = 32;
    localparam int REG_IDX_W = 5;

    // Data or address word
    typedef logic [WORD_W-1:0] word_t;

    // Architectural register index
    typedef logic [REG_IDX_W-1:0] reg_idx_t;

    // Fault info reported by the MEM pipe
    typedef struct packed {
        // PC of the faulting load or store
        word_t pc;
        // Virtual address that missed or faulted
        word_t vaddr;
    } mem_fault_t;

endpackage

`default_nettype wire

// File: hw/rob_pkg.sv
`default_nettype none

package rob_pkg;

    // Number of reorder buffer entries
    localparam int ROB_ENTRIES = 8;

    // Entry id width, count needs one more bit to hold ROB_ENTRIES
    localparam int ROB_ID_W  = $clog2(ROB_ENTRIES);
    localparam int ROB_CNT_W = ROB_ID_W + 1;

    // Entry id, also the bypass tag seen by rename
    typedef logic [ROB_ID_W-1:0] rob_id_t;

    // Occupancy, 0 to ROB_ENTRIES
    typedef logic [ROB_CNT_W-1:0] rob_cnt_t;

    // Id handed to decode when nothing was allocated
    // Only meaningful next to a low grant, every code is a real entry
    localparam rob_id_t ROB_INVALID_ID = rob_id_t'(0);

    // Exception cause at retire
    typedef enum logic [1:0] {
        // No exception this cycle
        EXC_NONE = 2'd0,
        // Instruction fetch translation fault, reported by decode
        EXC_ITLB = 2'd1,
        // Load/store fault, reported by the MEM writeback port
        EXC_MEM  = 2'd2
    } exc_cause_t;

endpackage

`default_nettype wire

// File: hw/rob_ptr_ctrl.sv
`default_nettype none

module rob_ptr_ctrl (
    input  wire                clk,
    input  wire                arst_n,
    output logic               alloc_grant,
    input  wire                retire,
    input  wire                flush,
    input  wire                hold,
    input  wire                alloc_req,
    output rob_pkg::rob_id_t   head,
    output rob_pkg::rob_id_t   tail,
    output rob_pkg::rob_cnt_t  count,
    output logic               full
);

    import rob_pkg::*;

    rob_id_t head_nxt;
    rob_id_t tail_nxt;

    // Wrap at ROB_ENTRIES
    assign head_nxt = (head == rob_id_t'(ROB_ENTRIES - 1)) ? '0 : head + 1'b1;
    assign tail_nxt = (tail == rob_id_t'(ROB_ENTRIES - 1)) ? '0 : tail + 1'b1;

    // Hold blocks decode during exception and flush
    assign full        = (count == rob_cnt_t'(ROB_ENTRIES)) | hold;
    assign alloc_grant = alloc_req & ~full;

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else if (flush) begin
            // Whole buffer dropped
            head  <= '0;
            tail  <= '0;
            count <= '0;
        end else begin
            if (retire) begin
                head <= head_nxt;
            end
            if (alloc_grant) begin
                tail <= tail_nxt;
            end
            // Retire and allocate together leave count alone
            case ({alloc_grant, retire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // Occupancy stays within the buffer
    assert property (@(posedge clk) disable iff (!arst_n)
        count <= rob_cnt_t'(ROB_ENTRIES));

    // Retire logic must see a live head
    assert property (@(posedge clk) disable iff (!arst_n)
        retire |-> (count != '0));

endmodule

`default_nettype wire

// File: hw/rob_flush_fsm.sv
`default_nettype none

module rob_flush_fsm (
    input  wire   clk,
    input  wire   arst_n,
    input  wire   exception,
    output logic  flush,
    output logic  hold
);

    // RUN for normal operation and FLUSH to drop every entry
    typedef enum logic {
        RUN   = 1'b0,
        FLUSH = 1'b1
    } state_t;

    state_t state;
    state_t state_nxt;

    always_comb begin
        state_nxt = state;
        case (state)
            RUN: begin
                // Exception cycle with the flush on the next one
                if (exception) begin
                    state_nxt = FLUSH;
                end
            end
            FLUSH: begin
                // Always back to RUN after one cycle
                state_nxt = RUN;
            end
            default: begin
                state_nxt = RUN;
            end
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state <= RUN;
        end else begin
            state <= state_nxt;
        end
    end

    assign flush = (state == FLUSH);

    // Decode and retire frozen for exception plus flush cycle
    assign hold = exception | flush;

    // An exception raised in FLUSH would get no flush cycle of its own
    assert property (@(posedge clk) disable iff (!arst_n)
        exception |=> flush);

endmodule

`default_nettype wire

// File: hw/rob_entry_array.sv
`default_nettype none

module rob_entry_array (
    input  wire                clk,
    input  wire                arst_n,
    input  wire                flush,
    input  wire                alloc,
    input  wire rob_pkg::rob_id_t   tail,
    input  wire core_pkg::reg_idx_t rd,
    input  wire                is_store,
    input  wire                d_exception,
    input  wire                alu_wen,
    input  wire rob_pkg::rob_id_t   alu_id,
    input  wire core_pkg::word_t    alu_result,
    input  wire                mem_wen,
    input  wire rob_pkg::rob_id_t   mem_id,
    input  wire core_pkg::word_t    mem_result,
    input  wire                mul_wen,
    input  wire rob_pkg::rob_id_t   mul_id,
    input  wire core_pkg::word_t    mul_result,
    input  wire rob_pkg::rob_id_t   rs1_id,
    input  wire rob_pkg::rob_id_t   rs2_id,
    input  wire rob_pkg::rob_id_t   head,
    output logic               head_ready,
    output logic               head_store,
    output core_pkg::reg_idx_t head_rd,
    output core_pkg::word_t    head_value,
    output core_pkg::word_t    bypass_s1,
    output logic               bypass_s1_valid,
    output core_pkg::word_t    bypass_s2,
    output logic               bypass_s2_valid
);

    import core_pkg::*;
    import rob_pkg::*;

    // Per-entry storage
    reg_idx_t                 rds    [ROB_ENTRIES];
    word_t                    values [ROB_ENTRIES];
    logic [ROB_ENTRIES-1:0]   readys;
    logic [ROB_ENTRIES-1:0]   stores;

    // Ready and store flags
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            readys <= '0;
            stores <= '0;
        end else if (flush) begin
            // Pending writebacks lose against the flush
            readys <= '0;
            stores <= '0;
        end else begin
            if (alloc) begin
                // ITLB-killed entry is finished on arrival
                readys[tail] <= d_exception;
                stores[tail] <= is_store;
            end
            if (alu_wen) begin
                readys[alu_id] <= 1'b1;
            end
            if (mem_wen) begin
                readys[mem_id] <= 1'b1;
            end
            if (mul_wen) begin
                readys[mul_id] <= 1'b1;
            end
        end
    end

    // Destination and result payload
    always_ff @(posedge clk) begin
        if (alloc) begin
            rds[tail]    <= rd;
            values[tail] <= '0;
        end
        if (alu_wen) begin
            values[alu_id] <= alu_result;
        end
        if (mem_wen) begin
            values[mem_id] <= mem_result;
        end
        if (mul_wen) begin
            values[mul_id] <= mul_result;
        end
    end

    // Head view for retire
    assign head_ready = readys[head];
    assign head_store = stores[head];
    assign head_rd    = rds[head];
    assign head_value = values[head];

    // Source operand bypass
    assign bypass_s1       = values[rs1_id];
    assign bypass_s1_valid = readys[rs1_id];
    assign bypass_s2       = values[rs2_id];
    assign bypass_s2_valid = readys[rs2_id];

    // Issue never sends one entry down two pipes
    assert property (@(posedge clk) disable iff (!arst_n)
        !((alu_wen && mem_wen && alu_id == mem_id) ||
          (alu_wen && mul_wen && alu_id == mul_id) ||
          (mem_wen && mul_wen && mem_id == mul_id)));

endmodule

`default_nettype wire

// File: hw/rob_exc_slot.sv
`default_nettype none

module rob_exc_slot #(
    parameter type payload_t = core_pkg::word_t
) (
    input  wire                     clk,
    input  wire                     arst_n,
    input  wire                     flush,
    input  wire                     record,
    input  wire rob_pkg::rob_id_t   rec_id,
    input  wire payload_t           rec_payload,
    input  wire rob_pkg::rob_id_t   head,
    input  wire                     head_ready,
    output logic                    hit,
    output payload_t                payload
);

    import rob_pkg::*;

    logic    valid;
    rob_id_t held_id;
    // Distance from head, smaller is older
    rob_id_t rec_age;
    rob_id_t held_age;
    logic    take;

    assign rec_age  = rec_id - head;
    assign held_age = held_id - head;

    // Empty slot takes anything, else only an older fault
    assign take = record & (~valid | (rec_age < held_age));

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            valid   <= 1'b0;
            held_id <= '0;
        end else if (flush) begin
            valid <= 1'b0;
        end else if (take) begin
            valid   <= 1'b1;
            held_id <= rec_id;
        end
    end

    // Fault details, only read while valid
    always_ff @(posedge clk) begin
        if (take) begin
            payload <= rec_payload;
        end
    end

    // Faulting entry at the head, masked while the flush runs
    assign hit = valid & (held_id == head) & head_ready & ~flush;

    // Every hit is followed by exactly the flush cycle
    assert property (@(posedge clk) disable iff (!arst_n)
        hit |=> flush);

endmodule

`default_nettype wire

// File: hw/rob_top.sv
`default_nettype none

module rob_top (
    input  wire                      clk,
    input  wire                      arst_n,
    // Decode
    input  wire                      alloc_req,
    input  wire                      is_store,
    input  wire core_pkg::reg_idx_t  rd,
    input  wire                      d_exception,
    input  wire core_pkg::word_t     d_pc,
    output rob_pkg::rob_id_t         assigned_id,
    output logic                     alloc_grant,
    output logic                     full,
    // ALU writeback
    input  wire                      alu_wen,
    input  wire rob_pkg::rob_id_t    alu_id,
    input  wire core_pkg::word_t     alu_result,
    // MEM writeback with fault info
    input  wire                      mem_wen,
    input  wire rob_pkg::rob_id_t    mem_id,
    input  wire core_pkg::word_t     mem_result,
    input  wire                      mem_exception,
    input  wire core_pkg::word_t     mem_pc,
    input  wire core_pkg::word_t     mem_vaddr,
    // MUL writeback
    input  wire                      mul_wen,
    input  wire rob_pkg::rob_id_t    mul_id,
    input  wire core_pkg::word_t     mul_result,
    // Bypass
    input  wire rob_pkg::rob_id_t    rs1_id,
    input  wire rob_pkg::rob_id_t    rs2_id,
    output core_pkg::word_t          bypass_s1,
    output logic                     bypass_s1_valid,
    output core_pkg::word_t          bypass_s2,
    output logic                     bypass_s2_valid,
    // Register file commit
    output logic                     commit,
    output core_pkg::reg_idx_t       commit_rd,
    output core_pkg::word_t          commit_value,
    output rob_pkg::rob_id_t         commit_id,
    // Store buffer
    output logic                     sb_store_permission,
    output rob_pkg::rob_id_t         sb_id,
    // Exception
    output logic                     exception,
    output rob_pkg::exc_cause_t      ex_cause,
    output core_pkg::word_t          ex_pc,
    output core_pkg::word_t          ex_vaddr
);

    import core_pkg::*;
    import rob_pkg::*;

    rob_id_t    head;
    rob_id_t    tail;
    rob_cnt_t   count;
    logic       head_ready;
    logic       head_live;
    logic       head_store;
    reg_idx_t   head_rd;
    word_t      head_value;
    logic       retire;
    logic       flush;
    logic       hold;
    logic       itlb_record;
    logic       itlb_hit;
    word_t      itlb_pc;
    logic       mem_record;
    logic       mem_hit;
    mem_fault_t mem_rec_payload;
    mem_fault_t mem_fault;

    // Stale ready bit of an empty head is ignored
    assign head_live = head_ready & (count != '0);
    assign retire    = head_live & ~hold;

    assign assigned_id = alloc_grant ? tail : ROB_INVALID_ID;

    // Retire split between register file and store buffer
    assign commit              = retire & ~head_store;
    assign commit_rd           = head_rd;
    assign commit_value        = head_value;
    assign commit_id           = head;
    assign sb_store_permission = retire & head_store;
    assign sb_id               = head;

    // Fault capture
    assign itlb_record     = alloc_grant & d_exception;
    assign mem_record      = mem_wen & mem_exception;
    assign mem_rec_payload = '{pc: mem_pc, vaddr: mem_vaddr};

    // ITLB first, it has no vaddr
    assign exception = itlb_hit | mem_hit;
    assign ex_cause  = itlb_hit ? EXC_ITLB : (mem_hit ? EXC_MEM : EXC_NONE);
    assign ex_pc     = itlb_hit ? itlb_pc : (mem_hit ? mem_fault.pc : '0);
    assign ex_vaddr  = (mem_hit & ~itlb_hit) ? mem_fault.vaddr : '0;

    rob_ptr_ctrl u_ptr (
        .clk(clk), .arst_n(arst_n), .alloc_grant(alloc_grant), .retire(retire),
        .flush(flush), .hold(hold), .alloc_req(alloc_req), .head(head),
        .tail(tail), .count(count), .full(full)
    );

    rob_flush_fsm u_fsm (
        .clk(clk), .arst_n(arst_n), .exception(exception), .flush(flush), .hold(hold)
    );

    rob_entry_array u_array (
        .clk(clk), .arst_n(arst_n), .flush(flush), .alloc(alloc_grant),
        .tail(tail), .rd(rd), .is_store(is_store), .d_exception(d_exception),
        .alu_wen(alu_wen), .alu_id(alu_id), .alu_result(alu_result),
        .mem_wen(mem_wen), .mem_id(mem_id), .mem_result(mem_result),
        .mul_wen(mul_wen), .mul_id(mul_id), .mul_result(mul_result),
        .rs1_id(rs1_id), .rs2_id(rs2_id), .head(head),
        .head_ready(head_ready), .head_store(head_store),
        .head_rd(head_rd), .head_value(head_value),
        .bypass_s1(bypass_s1), .bypass_s1_valid(bypass_s1_valid),
        .bypass_s2(bypass_s2), .bypass_s2_valid(bypass_s2_valid)
    );

    // ITLB fault keeps the PC only
    rob_exc_slot #(.payload_t(word_t)) u_itlb_slot (
        .clk(clk), .arst_n(arst_n), .flush(flush), .record(itlb_record),
        .rec_id(tail), .rec_payload(d_pc), .head(head), .head_ready(head_live),
        .hit(itlb_hit), .payload(itlb_pc)
    );

    // MEM fault keeps PC and vaddr
    rob_exc_slot #(.payload_t(mem_fault_t)) u_mem_slot (
        .clk(clk), .arst_n(arst_n), .flush(flush), .record(mem_record),
        .rec_id(mem_id), .rec_payload(mem_rec_payload), .head(head),
        .head_ready(head_live), .hit(mem_hit), .payload(mem_fault)
    );

endmodule

`default_nettype wire

// File: bench/rob_tb_cases.svh
    // Stim: alloc_req is_store rd d_exception pc | wb_port wb_id wb_val mem_exception vaddr | rs1 rs2
    // Exp: full grant id | retire ret_id rd value | cause pc vaddr | s1_valid s1 s2_valid s2
    // Four allocations, writebacks in reverse, commits in program order
    add_row('{1,0,1,0,0, 0,0,0,0,0, 0,0,  0,1,0, 0,0,0,0, 0,0,0, 0,0,0,0});
    add_row('{1,0,2,0,0, 0,0,0,0,0, 0,0,  0,1,1, 0,0,0,0, 0,0,0, 0,0,0,0});
    add_row('{1,0,3,0,0, 0,0,0,0,0, 0,0,  0,1,2, 0,0,0,0, 0,0,0, 0,0,0,0});
    add_row('{1,0,4,0,0, 0,0,0,0,0, 0,0,  0,1,3, 0,0,0,0, 0,0,0, 0,0,0,0});
    add_row('{0,0,0,0,0, 1,3,'h33,0,0, 3,2,  0,0,0, 0,0,0,0, 0,0,0, 0,0,0,0});
    add_row('{0,0,0,0,0, 3,2,'h22,0,0, 3,2,  0,0,0, 0,0,0,0, 0,0,0, 1,'h33,0,0});
    add_row('{0,0,0,0,0, 2,1,'h11,0,0, 3,2,  0,0,0, 0,0,0,0, 0,0,0, 1,'h33,1,'h22});
    add_row('{0,0,0,0,0, 1,0,'h10,0,0, 1,0,  0,0,0, 0,0,0,0, 0,0,0, 1,'h11,0,0});
    // Store allocated while the oldest commits
    add_row('{1,1,0,0,0, 0,0,0,0,0, 0,0,  0,1,4, 1,0,1,'h10, 0,0,0, 1,'h10,1,'h10});
    add_row('{0,0,0,0,0, 2,4,'h44,0,0, 0,0,  0,0,0, 1,1,2,'h11, 0,0,0, 1,'h10,1,'h10});
    add_row('{0,0,0,0,0, 0,0,0,0,0, 0,0,  0,0,0, 1,2,3,'h22, 0,0,0, 1,'h10,1,'h10});
    add_row('{0,0,0,0,0, 0,0,0,0,0, 0,0,  0,0,0, 1,3,4,'h33, 0,0,0, 1,'h10,1,'h10});
    add_row('{0,0,0,0,0, 0,0,0,0,0, 0,0,  0,0,0, 2,4,0,0, 0,0,0, 1,'h10,1,'h10});
    // Eight allocations fill the buffer, slot 0 reused
    add_row('{1,0,13,0,0, 0,0,0,0,0, 0,0,  0,1,5, 0,0,0,0, 0,0,0, 1,'h10,1,'h10});
    add_row('{1,0,14,0,0, 0,0,0,0,0, 0,0,  0,1,6, 0,0,0,0, 0,0,0, 1,'h10,1,'h10});
    add_row('{1,0,15,0,0, 0,0,0,0,0, 0,0,  0,1,7, 0,0,0,0, 0,0,0, 1,'h10,1,'h10});
    add_row('{1,0,8,0,0, 0,0,0,0,0, 0,0,  0,1,0, 0,0,0,0, 0,0,0, 1,'h10,1,'h10});
    add_row('{1,0,9,0,0, 0,0,0,0,0, 0,0,  0,1,1, 0,0,0,0, 0,0,0, 0,0,0,0});
    add_row('{1,0,10,0,0, 0,0,0,0,0, 0,0,  0,1,2, 0,0,0,0, 0,0,0, 0,0,0,0});
    add_row('{1,0,11,0,0, 0,0,0,0,0, 0,0,  0,1,3, 0,0,0,0, 0,0,0, 0,0,0,0});
    add_row('{1,0,12,0,0, 0,0,0,0,0, 0,0,  0,1,4, 0,0,0,0, 0,0,0, 0,0,0,0});
    // Ninth request refused
    add_row('{1,0,0,0,0, 1,5,'h55,0,0, 0,0,  1,0,0, 0,0,0,0, 0,0,0, 0,0,0,0});
    add_row('{1,0,0,0,0, 1,6,'h66,0,0, 0,0,  1,0,0, 1,5,13,'h55, 0,0,0, 0,0,0,0});
    // Retire plus allocate, count stays at seven
    add_row('{1,0,20,0,0, 0,0,0,0,0, 0,0,  0,1,5, 1,6,14,'h66, 0,0,0, 0,0,0,0});
    add_row('{1,0,21,0,0, 0,0,0,0,0, 0,0,  0,1,6, 0,0,0,0, 0,0,0, 0,0,0,0});
    add_row('{1,0,0,0,0, 0,0,0,0,0, 0,0,  1,0,0, 0,0,0,0, 0,0,0, 0,0,0,0});
    // MEM faults, younger id 1 first, then older id 0
    add_row('{0,0,0,0,'h200, 2,1,'h01,1,'h1100, 0,0,  1,0,0, 0,0,0,0, 0,0,0, 0,0,0,0});
    add_row('{0,0,0,0,'h300, 2,0,'h0c,1,'h3000, 0,0,  1,0,0, 0,0,0,0, 0,0,0, 0,0,0,0});
    add_row('{0,0,0,0,0, 1,7,'h77,0,0, 0,0,  1,0,0, 0,0,0,0, 0,0,0, 1,'h0c,1,'h0c});
    add_row('{0,0,0,0,0, 0,0,0,0,0, 0,0,  1,0,0, 1,7,15,'h77, 0,0,0, 1,'h0c,1,'h0c});
    // Exception cycle then flush cycle
    add_row('{1,0,0,0,0, 0,0,0,0,0, 0,0,  1,0,0, 0,0,0,0, 2,'h300,'h3000, 1,'h0c,1,'h0c});
    add_row('{1,0,0,0,0, 0,0,0,0,0, 0,0,  1,0,0, 0,0,0,0, 0,0,0, 1,'h0c,1,'h0c});
    // Restart empty, then an ITLB-killed allocation
    add_row('{1,0,3,0,0, 0,0,0,0,0, 0,0,  0,1,0, 0,0,0,0, 0,0,0, 0,0,0,0});
    add_row('{1,0,5,1,'h400, 0,0,0,0,0, 0,0,  0,1,1, 0,0,0,0, 0,0,0, 0,0,0,0});
    add_row('{0,0,0,0,0, 1,0,'ha0,0,0, 1,0,  0,0,0, 0,0,0,0, 0,0,0, 1,0,0,0});
    add_row('{0,0,0,0,0, 0,0,0,0,0, 0,0,  0,0,0, 1,0,3,'ha0, 0,0,0, 1,'ha0,1,'ha0});
    add_row('{0,0,0,0,0, 0,0,0,0,0, 0,0,  1,0,0, 0,0,0,0, 1,'h400,0, 1,'ha0,1,'ha0});
    add_row('{0,0,0,0,0, 0,0,0,0,0, 0,0,  1,0,0, 0,0,0,0, 0,0,0, 1,'ha0,1,'ha0});
    add_row('{0,0,0,0,0, 0,0,0,0,0, 0,0,  0,0,0, 0,0,0,0, 0,0,0, 0,0,0,0});

// File: bench/rob_tb.sv
`default_nettype none

module rob_tb;

    import core_pkg::*;
    import rob_pkg::*;

    localparam int CLK_HALF     = 2;
    localparam int RESET_CYCLES = 8;
    localparam int SLACK_CYCLES = 20;
    localparam int DRIVE_DELAY  = 1;
    // Lands one unit ahead of the next rising edge
    localparam int SAMPLE_DELAY = 2;

    // One table row per cycle with stimulus ahead of expected outputs
    typedef struct packed {
        logic       alloc;
        logic       store;
        reg_idx_t   rd;
        logic       d_exc;
        // Feeds d_pc on allocation and mem_pc on a MEM writeback
        word_t      pc;
        // 0 none, 1 alu, 2 mem, 3 mul
        logic [1:0] wb_port;
        rob_id_t    wb_id;
        word_t      wb_val;
        logic       m_exc;
        word_t      vaddr;
        rob_id_t    rs1;
        rob_id_t    rs2;
        logic       full;
        logic       grant;
        rob_id_t    aid;
        // 0 none, 1 commit, 2 store permission
        logic [1:0] retire;
        rob_id_t    ret_id;
        reg_idx_t   c_rd;
        word_t      c_val;
        // 0 none, 1 itlb, 2 mem
        logic [1:0] cause;
        word_t      e_pc;
        word_t      e_vaddr;
        logic       s1_v;
        word_t      s1;
        logic       s2_v;
        word_t      s2;
    } row_t;

    // DUT side
    logic       clk;
    logic       arst_n;
    logic       alloc_req;
    logic       is_store;
    reg_idx_t   rd;
    logic       d_exception;
    word_t      d_pc;
    rob_id_t    assigned_id;
    logic       alloc_grant;
    logic       full;
    logic       alu_wen;
    rob_id_t    alu_id;
    word_t      alu_result;
    logic       mem_wen;
    rob_id_t    mem_id;
    word_t      mem_result;
    logic       mem_exception;
    word_t      mem_pc;
    word_t      mem_vaddr;
    logic       mul_wen;
    rob_id_t    mul_id;
    word_t      mul_result;
    rob_id_t    rs1_id;
    rob_id_t    rs2_id;
    word_t      bypass_s1;
    logic       bypass_s1_valid;
    word_t      bypass_s2;
    logic       bypass_s2_valid;
    logic       commit;
    reg_idx_t   commit_rd;
    word_t      commit_value;
    rob_id_t    commit_id;
    logic       sb_store_permission;
    rob_id_t    sb_id;
    logic       exception;
    exc_cause_t ex_cause;
    word_t      ex_pc;
    word_t      ex_vaddr;

    // Bookkeeping
    row_t rows[$];
    logic table_built;
    int   checks;
    int   errors;
    int   row_errors;
    int   cur_row;
    int   cycles;

    rob_top UUT (.*);

    function automatic void add_row(input row_t r);
        rows.push_back(r);
    endfunction

    function automatic void build_table();
        `include "rob_tb_cases.svh"
    endfunction

    // Counts one compare and reports a mismatch in hex
    task automatic note_result(input string name, input logic bad, input word_t got,
                               input word_t exp);
        checks++;
        if (bad) begin
            errors++;
            row_errors++;
            $display("Fail row %0d %s: got %0h, expected %0h", cur_row, name, got, exp);
        end
    endtask

    task automatic check_word(input string name, input word_t got, input word_t exp);
        note_result(name, got !== exp, got, exp);
    endtask

    task automatic check_reg(input string name, input reg_idx_t got, input reg_idx_t exp);
        note_result(name, got !== exp, word_t'(got), word_t'(exp));
    endtask

    task automatic check_id(input string name, input rob_id_t got, input rob_id_t exp);
        note_result(name, got !== exp, word_t'(got), word_t'(exp));
    endtask

    task automatic check_cause(input string name, input exc_cause_t got,
                               input exc_cause_t exp);
        note_result(name, got !== exp, word_t'(got), word_t'(exp));
    endtask

    task automatic check_bit(input string name, input logic got, input logic exp);
        note_result(name, got !== exp, word_t'(got), word_t'(exp));
    endtask

    // Idle writeback ports see inverted id, result and pc
    task automatic drive_row(input row_t r);
        alloc_req     = r.alloc;
        is_store      = r.store;
        rd            = r.rd;
        d_exception   = r.d_exc;
        d_pc          = r.alloc ? r.pc : ~r.pc;
        alu_wen       = (r.wb_port == 2'd1);
        alu_id        = alu_wen ? r.wb_id : ~r.wb_id;
        alu_result    = alu_wen ? r.wb_val : ~r.wb_val;
        mem_wen       = (r.wb_port == 2'd2);
        mem_id        = mem_wen ? r.wb_id : ~r.wb_id;
        mem_result    = mem_wen ? r.wb_val : ~r.wb_val;
        mem_exception = r.m_exc;
        mem_pc        = mem_wen ? r.pc : ~r.pc;
        mem_vaddr     = mem_wen ? r.vaddr : ~r.vaddr;
        mul_wen       = (r.wb_port == 2'd3);
        mul_id        = mul_wen ? r.wb_id : ~r.wb_id;
        mul_result    = mul_wen ? r.wb_val : ~r.wb_val;
        rs1_id        = r.rs1;
        rs2_id        = r.rs2;
    endtask

    task automatic check_row(input row_t r);
        check_bit("full", full, r.full);
        check_bit("alloc_grant", alloc_grant, r.grant);
        check_id("assigned_id", assigned_id, r.aid);
        check_bit("commit", commit, r.retire == 2'd1);
        check_bit("sb_store_permission", sb_store_permission, r.retire == 2'd2);
        // Retire payload only means something on a retire
        if (r.retire == 2'd1) begin
            check_id("commit_id", commit_id, r.ret_id);
            check_reg("commit_rd", commit_rd, r.c_rd);
            check_word("commit_value", commit_value, r.c_val);
        end
        if (r.retire == 2'd2) begin
            check_id("sb_id", sb_id, r.ret_id);
        end
        check_bit("exception", exception, r.cause != 2'd0);
        check_cause("ex_cause", ex_cause, exc_cause_t'(r.cause));
        check_word("ex_pc", ex_pc, r.e_pc);
        check_word("ex_vaddr", ex_vaddr, r.e_vaddr);
        // Value of a not-ready entry is don't care
        check_bit("bypass_s1_valid", bypass_s1_valid, r.s1_v);
        if (r.s1_v) begin
            check_word("bypass_s1", bypass_s1, r.s1);
        end
        check_bit("bypass_s2_valid", bypass_s2_valid, r.s2_v);
        if (r.s2_v) begin
            check_word("bypass_s2", bypass_s2, r.s2);
        end
    endtask

    // Free running clock
    initial begin
        clk = 1'b0;
        forever begin
            #CLK_HALF;
            clk = ~clk;
        end
    end

    // Watchdog sized from the table
    initial begin
        cycles = 0;
        wait (table_built);
        while (cycles < rows.size() + RESET_CYCLES + SLACK_CYCLES) begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout: run still going after %0d cycles", cycles);
        $display("Done: errors found");
        $finish;
    end

    initial begin
        table_built = 1'b0;
        checks      = 0;
        errors      = 0;
        row_errors  = 0;
        cur_row     = 0;
        arst_n      = 1'b0;
        drive_row('0);
        build_table();
        table_built = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DELAY;
        arst_n = 1'b1;
        for (int i = 0; i < rows.size(); i++) begin
            @(posedge clk);
            #DRIVE_DELAY;
            drive_row(rows[i]);
            #SAMPLE_DELAY;
            cur_row    = i;
            row_errors = 0;
            check_row(rows[i]);
            if (row_errors == 0) begin
                $display("Row %0d: ok", i);
            end else begin
                $display("Row %0d: %0d mismatches", i, row_errors);
            end
        end
        $display("Rows %0d, checks %0d, mismatches %0d", rows.size(), checks, errors);
        if (errors == 0) begin
            $display("Done: no errors");
        end else begin
            $display("Done: errors found");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: rob.f
+incdir+bench
hw/core_pkg.sv
hw/rob_pkg.sv
hw/rob_ptr_ctrl.sv
hw/rob_flush_fsm.sv
hw/rob_entry_array.sv
hw/rob_exc_slot.sv
hw/rob_top.sv
bench/rob_tb.sv

// File: Makefile
TOP = rob_tb

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build the reorder buffer testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build folder"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -j 0 -f rob.f --top-module $(TOP) --Mdir obj_dir
	@out="$$(./obj_dir/V$(TOP))"; echo "$$out"; echo "$$out" | grep -q "Done: no errors"

clean:
	rm -rf obj_dir
